// ==== logic/ctrlPkg.sv ====
package ctrlPkg;

    // Operations the execute stage can perform
    typedef enum logic [2:0] {
        pass  = 3'd0,   // Operand B straight through
        add   = 3'd1,
        sub   = 3'd2,
        andOp = 3'd3,
        orOp  = 3'd4,
        shl   = 3'd5,
        shr   = 3'd6
    } aluOpT;

    // Branch tests on the value of ra
    typedef enum logic [1:0] {
        zero    = 2'd0,
        nonzero = 2'd1,
        plus    = 2'd2,
        minus   = 2'd3
    } brCondT;

    // Decode to execute
    typedef struct packed {
        logic            valid;
        aluOpT           aluOp;
        isaPkg::regIdxT  srcA;
        isaPkg::regIdxT  srcB;
        isaPkg::regIdxT  dest;
        isaPkg::wordT    immediate;   // Already sign-extended
        logic            useImm;
        logic            writeEn;
        logic            isIn;
        logic            isOut;
        logic            isBranch;
        brCondT          brCond;
    } decodedOpT;

    // Execute to result
    typedef struct packed {
        logic            valid;
        isaPkg::regIdxT  dest;
        logic            writeEn;
        isaPkg::wordT    value;
        logic            isOut;
        logic            isBranch;
        logic            taken;
        isaPkg::wordT    offset;
    } resultT;

endpackage

// ==== logic/execUnit.sv ====
module execUnit (
    input  logic               clk,
    input  logic               rstN,
    input  ctrlPkg::decodedOpT decoded,
    input  logic               stall,
    input  isaPkg::wordT       inPort,
    output isaPkg::regIdxT     rdIdxA,
    output isaPkg::regIdxT     rdIdxB,
    input  isaPkg::wordT       rdDataA,
    input  isaPkg::wordT       rdDataB,
    input  ctrlPkg::resultT    bypass,
    output ctrlPkg::resultT    result
);

    logic            hitA;
    logic            hitB;
    isaPkg::wordT    opA;
    isaPkg::wordT    regB;
    isaPkg::wordT    opB;
    isaPkg::wordT    aluOut;
    logic            condMet;
    ctrlPkg::resultT nextResult;

    assign rdIdxA = decoded.srcA;
    assign rdIdxB = decoded.srcB;

    // The op in the result stage writes back at the coming edge,
    // so its value is newer than the register file contents
    assign hitA = bypass.valid && bypass.writeEn && (bypass.dest == decoded.srcA);
    assign hitB = bypass.valid && bypass.writeEn && (bypass.dest == decoded.srcB);

    assign opA  = hitA ? bypass.value : rdDataA;
    assign regB = hitB ? bypass.value : rdDataB;
    assign opB  = decoded.useImm ? decoded.immediate : regB;

    always_comb begin
        case (decoded.aluOp)
            ctrlPkg::pass:  aluOut = opB;
            ctrlPkg::add:   aluOut = opA + opB;
            ctrlPkg::sub:   aluOut = opA - opB;
            ctrlPkg::andOp: aluOut = opA & opB;
            ctrlPkg::orOp:  aluOut = opA | opB;
            ctrlPkg::shl:   aluOut = opA << opB[4:0];
            ctrlPkg::shr:   aluOut = opA >> opB[4:0];   // Logical
            default:        aluOut = opB;
        endcase
    end

    // Branch tests look at ra, which sits on operand A
    always_comb begin
        case (decoded.brCond)
            ctrlPkg::zero:    condMet = (opA == '0);
            ctrlPkg::nonzero: condMet = (opA != '0);
            ctrlPkg::plus:    condMet = !opA[31];
            ctrlPkg::minus:   condMet = opA[31];
        endcase
    end

    always_comb begin
        nextResult.valid    = decoded.valid;
        nextResult.dest     = decoded.dest;
        nextResult.writeEn  = decoded.writeEn;
        nextResult.value    = decoded.isIn ? inPort : aluOut;   // Input port sampled here
        nextResult.isOut    = decoded.isOut;
        nextResult.isBranch = decoded.isBranch;
        nextResult.taken    = decoded.isBranch && condMet;
        nextResult.offset   = decoded.immediate;
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            result <= '0;
        end else if (!stall) begin
            result <= nextResult;
        end
    end

endmodule

// ==== logic/instrDecoder.sv ====
module instrDecoder (
    input  logic               clk,
    input  logic               rstN,
    input  isaPkg::instrT      instr,
    input  logic               instrValid,
    input  logic               stall,
    output logic               instrReady,
    output ctrlPkg::decodedOpT decoded
);

    isaPkg::rFormatT    rForm;
    isaPkg::iFormatT    iForm;
    isaPkg::wordT       constExt;
    ctrlPkg::decodedOpT nextOp;
    logic               accept;

    assign rForm    = instr.r;
    assign iForm    = instr.i;
    assign constExt = {{13{iForm.c[18]}}, iForm.c};

    assign instrReady = !stall;
    assign accept     = instrValid && instrReady;

    always_comb begin
        nextOp       = '0;
        nextOp.valid = 1'b1;        // Anything unrecognised runs as a nop
        nextOp.aluOp = ctrlPkg::pass;
        case (rForm.opcode)
            isaPkg::add, isaPkg::sub, isaPkg::andOp, isaPkg::orOp,
            isaPkg::shl, isaPkg::shr: begin
                nextOp.srcA    = rForm.rb;
                nextOp.srcB    = rForm.rc;
                nextOp.dest    = rForm.ra;
                nextOp.writeEn = 1'b1;
                case (rForm.opcode)
                    isaPkg::add:   nextOp.aluOp = ctrlPkg::add;
                    isaPkg::sub:   nextOp.aluOp = ctrlPkg::sub;
                    isaPkg::andOp: nextOp.aluOp = ctrlPkg::andOp;
                    isaPkg::orOp:  nextOp.aluOp = ctrlPkg::orOp;
                    isaPkg::shl:   nextOp.aluOp = ctrlPkg::shl;
                    default:       nextOp.aluOp = ctrlPkg::shr;
                endcase
            end
            isaPkg::addi, isaPkg::andi, isaPkg::ori: begin
                nextOp.srcA      = iForm.rb;
                nextOp.dest      = iForm.ra;
                nextOp.immediate = constExt;
                nextOp.useImm    = 1'b1;
                nextOp.writeEn   = 1'b1;
                case (iForm.opcode)
                    isaPkg::addi: nextOp.aluOp = ctrlPkg::add;
                    isaPkg::andi: nextOp.aluOp = ctrlPkg::andOp;
                    default:      nextOp.aluOp = ctrlPkg::orOp;
                endcase
            end
            isaPkg::ldi: begin
                nextOp.dest      = iForm.ra;
                nextOp.immediate = constExt;   // Passed through as operand B
                nextOp.useImm    = 1'b1;
                nextOp.writeEn   = 1'b1;
            end
            isaPkg::inOp: begin
                nextOp.dest    = iForm.ra;
                nextOp.writeEn = 1'b1;
                nextOp.isIn    = 1'b1;
            end
            isaPkg::outOp: begin
                nextOp.srcA  = iForm.ra;
                nextOp.srcB  = iForm.ra;       // Value leaves via the pass path
                nextOp.isOut = 1'b1;
            end
            isaPkg::brzr, isaPkg::brnz, isaPkg::brpl, isaPkg::brmi: begin
                nextOp.srcA      = iForm.ra;   // Condition register
                nextOp.immediate = constExt;   // PC offset
                nextOp.isBranch  = 1'b1;
                case (iForm.opcode)
                    isaPkg::brzr: nextOp.brCond = ctrlPkg::zero;
                    isaPkg::brnz: nextOp.brCond = ctrlPkg::nonzero;
                    isaPkg::brpl: nextOp.brCond = ctrlPkg::plus;
                    default:      nextOp.brCond = ctrlPkg::minus;
                endcase
            end
            default: ;
        endcase
    end

    // Bubble when nothing is accepted and hold under stall
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            decoded <= '0;
        end else if (!stall) begin
            decoded <= accept ? nextOp : '0;
        end
    end

endmodule

// ==== logic/isaPkg.sv ====
package isaPkg;

    // Register index and data word
    typedef logic [3:0]  regIdxT;
    typedef logic [31:0] wordT;

    // Opcode in the top five bits of every instruction
    typedef enum logic [4:0] {
        add   = 5'd0,
        sub   = 5'd1,
        andOp = 5'd2,
        orOp  = 5'd3,
        shl   = 5'd4,
        shr   = 5'd5,
        addi  = 5'd6,
        andi  = 5'd7,
        ori   = 5'd8,
        ldi   = 5'd9,
        inOp  = 5'd10,
        outOp = 5'd11,
        brzr  = 5'd12,
        brnz  = 5'd13,
        brpl  = 5'd14,
        brmi  = 5'd15,
        nop   = 5'd16
    } opcodeT;

    // Three-register format computing ra <= rb op rc
    typedef struct packed {
        opcodeT      opcode;   // [31:27]
        regIdxT      ra;       // [26:23]
        regIdxT      rb;       // [22:19]
        regIdxT      rc;       // [18:15]
        logic [14:0] unused;
    } rFormatT;

    // Register plus constant format
    // Branches compare ra and add c to the PC
    // ldi loads the sign-extended c into ra
    typedef struct packed {
        opcodeT             opcode;
        regIdxT             ra;
        regIdxT             rb;   // Don't care for branches and ldi
        logic signed [18:0] c;
    } iFormatT;

    // One instruction word seen in two formats
    typedef union packed {
        rFormatT r;
        iFormatT i;
    } instrT;

endpackage

// ==== logic/miniCore.sv ====
module miniCore #(
    parameter isaPkg::wordT resetPc = 32'h0
) (
    input  logic          clk,
    input  logic          rstN,
    input  isaPkg::instrT instr,
    input  logic          instrValid,
    output logic          instrReady,
    input  isaPkg::wordT  inPort,
    output isaPkg::wordT  outData,
    output logic          outValid,
    input  logic          outReady,
    output isaPkg::wordT  pc
);

    ctrlPkg::decodedOpT decoded;
    ctrlPkg::resultT    result;
    ctrlPkg::resultT    bypass;
    logic               stall;     // Whole pipeline freezes on output back-pressure
    isaPkg::regIdxT     rdIdxA;
    isaPkg::regIdxT     rdIdxB;
    isaPkg::wordT       rdDataA;
    isaPkg::wordT       rdDataB;
    logic               wrEn;
    isaPkg::regIdxT     wrIdx;
    isaPkg::wordT       wrData;

    instrDecoder u_instrDecoder (
        .clk        (clk),
        .rstN       (rstN),
        .instr      (instr),
        .instrValid (instrValid),
        .stall      (stall),
        .instrReady (instrReady),
        .decoded    (decoded)
    );

    execUnit u_execUnit (
        .clk     (clk),
        .rstN    (rstN),
        .decoded (decoded),
        .stall   (stall),
        .inPort  (inPort),
        .rdIdxA  (rdIdxA),
        .rdIdxB  (rdIdxB),
        .rdDataA (rdDataA),
        .rdDataB (rdDataB),
        .bypass  (bypass),
        .result  (result)
    );

    regFile u_regFile (
        .clk     (clk),
        .rstN    (rstN),
        .rdIdxA  (rdIdxA),
        .rdIdxB  (rdIdxB),
        .rdDataA (rdDataA),
        .rdDataB (rdDataB),
        .wrEn    (wrEn),
        .wrIdx   (wrIdx),
        .wrData  (wrData)
    );

    resultStage #(
        .resetPc (resetPc)
    ) u_resultStage (
        .clk      (clk),
        .rstN     (rstN),
        .result   (result),
        .outReady (outReady),
        .stall    (stall),
        .bypass   (bypass),
        .wrEn     (wrEn),
        .wrIdx    (wrIdx),
        .wrData   (wrData),
        .outValid (outValid),
        .outData  (outData),
        .pc       (pc)
    );

endmodule

// ==== logic/regFile.sv ====
module regFile (
    input  logic           clk,
    input  logic           rstN,
    input  isaPkg::regIdxT rdIdxA,
    input  isaPkg::regIdxT rdIdxB,
    output isaPkg::wordT   rdDataA,
    output isaPkg::wordT   rdDataB,
    input  logic           wrEn,
    input  isaPkg::regIdxT wrIdx,
    input  isaPkg::wordT   wrData
);

    isaPkg::wordT regs [0:15];

    // Reads see the old value during a write
    assign rdDataA = regs[rdIdxA];
    assign rdDataB = regs[rdIdxB];

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            for (int i = 0; i < 16; i++) begin
                regs[i] <= '0;
            end
        end else if (wrEn) begin
            regs[wrIdx] <= wrData;
        end
    end

endmodule

// ==== logic/resultStage.sv ====
module resultStage #(
    parameter isaPkg::wordT resetPc = 32'h0
) (
    input  logic            clk,
    input  logic            rstN,
    input  ctrlPkg::resultT result,
    input  logic            outReady,
    output logic            stall,
    output ctrlPkg::resultT bypass,
    output logic            wrEn,
    output isaPkg::regIdxT  wrIdx,
    output isaPkg::wordT    wrData,
    output logic            outValid,
    output isaPkg::wordT    outData,
    output isaPkg::wordT    pc
);

    logic         commit;
    isaPkg::wordT pcStep;

    assign bypass = result;

    // Writeback for every op except out
    assign wrEn   = result.valid && result.writeEn;
    assign wrIdx  = result.dest;
    assign wrData = result.value;

    // Out op waits here until the port takes it
    assign outValid = result.valid && result.isOut;
    assign outData  = result.value;
    assign stall    = outValid && !outReady;

    assign commit = result.valid && !stall;
    assign pcStep = (result.isBranch && result.taken) ? 32'd1 + result.offset : 32'd1;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            pc <= resetPc;
        end else if (commit) begin
            pc <= pc + pcStep;
        end
    end

endmodule

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the testbench, the exit status reports pass or fail
cd "$(dirname "$0")" &&
verilator --binary --timing --timescale 1ns/1ps --top-module coreTb -f src.f -o coreSim &&
./obj_dir/coreSim ||
exit 1

// ==== src.f ====
+incdir+tb
logic/isaPkg.sv
logic/ctrlPkg.sv
logic/regFile.sv
logic/instrDecoder.sv
logic/execUnit.sv
logic/resultStage.sv
logic/miniCore.sv
tb/coreTb.sv

// ==== tb/coreRef.svh ====
`ifndef CORE_REF_SVH
`define CORE_REF_SVH

// Model architectural state updated in acceptance order
isaPkg::wordT modelRegs [16];
isaPkg::wordT modelPc;

function automatic void clearModel(input isaPkg::wordT startPc);
    for (int i = 0; i < 16; i++) begin
        modelRegs[i] = '0;
    end
    modelPc = startPc;
endfunction

// Applies one instruction and returns 1 with the port value for an out
function automatic logic predict(input isaPkg::instrT ins, input isaPkg::wordT inVal,
                                 output isaPkg::wordT outVal);
    isaPkg::wordT aVal;
    isaPkg::wordT bVal;
    isaPkg::wordT cVal;
    isaPkg::wordT konst;
    logic         isOut;
    logic         taken;
    aVal   = modelRegs[ins.r.ra];
    bVal   = modelRegs[ins.r.rb];
    cVal   = modelRegs[ins.r.rc];
    konst  = 32'($signed(ins.i.c));           // Sign-extended constant
    outVal = '0;
    isOut  = 1'b0;
    taken  = 1'b0;
    case (ins.r.opcode)
        isaPkg::add:   modelRegs[ins.r.ra] = bVal + cVal;
        isaPkg::sub:   modelRegs[ins.r.ra] = bVal - cVal;
        isaPkg::andOp: modelRegs[ins.r.ra] = bVal & cVal;
        isaPkg::orOp:  modelRegs[ins.r.ra] = bVal | cVal;
        isaPkg::shl:   modelRegs[ins.r.ra] = bVal << cVal[4:0];
        isaPkg::shr:   modelRegs[ins.r.ra] = bVal >> cVal[4:0];
        isaPkg::addi:  modelRegs[ins.i.ra] = bVal + konst;
        isaPkg::andi:  modelRegs[ins.i.ra] = bVal & konst;
        isaPkg::ori:   modelRegs[ins.i.ra] = bVal | konst;
        isaPkg::ldi:   modelRegs[ins.i.ra] = konst;
        isaPkg::inOp:  modelRegs[ins.i.ra] = inVal;
        isaPkg::outOp: begin
            outVal = aVal;
            isOut  = 1'b1;
        end
        isaPkg::brzr:  taken = (aVal == '0);
        isaPkg::brnz:  taken = (aVal != '0);
        isaPkg::brpl:  taken = !aVal[31];
        isaPkg::brmi:  taken = aVal[31];
        default: ;                                // nop
    endcase
    // Every instruction advances the PC and a taken branch adds its offset
    modelPc = modelPc + 32'd1 + (taken ? konst : 32'd0);
    return isOut;
endfunction

`endif

// ==== tb/coreTb.sv ====
module coreTb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam isaPkg::wordT startPc     = 32'h0000_0100;
    localparam int           resetCycles = 8;

    logic          clk;
    logic          rstN;
    isaPkg::instrT instr;
    logic          instrValid;
    logic          instrReady;
    isaPkg::wordT  inPort;
    isaPkg::wordT  outData;
    logic          outValid;
    logic          outReady;
    isaPkg::wordT  pc;

    logic [31:0]   lfsrState;
    logic          pressure;      // Random outReady while set
    int            issued;
    int            cycles;
    isaPkg::wordT  expectQ [$];   // Out values still to be seen

    `include "coreRef.svh"

    miniCore #(
        .resetPc (startPc)
    ) u_miniCore (
        .clk        (clk),
        .rstN       (rstN),
        .instr      (instr),
        .instrValid (instrValid),
        .instrReady (instrReady),
        .inPort     (inPort),
        .outData    (outData),
        .outValid   (outValid),
        .outReady   (outReady),
        .pc         (pc)
    );

    always #5 clk = ~clk;

    task automatic stopOnError();
        $display("Testbench failed");
        $fatal(1, "Stopped at the first error");
    endtask

    function automatic logic [31:0] lfsrStep(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    // One LFSR step per bit
    function automatic logic [31:0] takeBits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsrState = lfsrStep(lfsrState);
            v = {v[30:0], lfsrState[0]};
        end
        return v;
    endfunction

    function automatic isaPkg::regIdxT randIdx();
        logic [31:0] v;
        v = takeBits(4);
        return v[3:0];
    endfunction

    function automatic logic [18:0] randConst();
        logic [31:0] v;
        v = takeBits(19);
        return v[18:0];
    endfunction

    function automatic isaPkg::instrT buildR(input isaPkg::opcodeT op, input isaPkg::regIdxT ra,
                                             input isaPkg::regIdxT rb, input isaPkg::regIdxT rc);
        isaPkg::instrT w;
        w          = '0;
        w.r.opcode = op;
        w.r.ra     = ra;
        w.r.rb     = rb;
        w.r.rc     = rc;
        return w;
    endfunction

    function automatic isaPkg::instrT buildI(input isaPkg::opcodeT op, input isaPkg::regIdxT ra,
                                             input isaPkg::regIdxT rb, input logic [18:0] c);
        isaPkg::instrT w;
        w          = '0;
        w.i.opcode = op;
        w.i.ra     = ra;
        w.i.rb     = rb;
        w.i.c      = c;
        return w;
    endfunction

    task automatic setOutReady();
        logic [31:0] bits;
        if (pressure) begin
            bits     = takeBits(1);
            outReady = bits[0];
        end else begin
            outReady = 1'b1;
        end
    endtask

    // Starts and ends on a falling edge with instr held until accepted
    task automatic issue(input isaPkg::instrT ins);
        logic         accepted;
        isaPkg::wordT outVal;
        instr      = ins;
        instrValid = 1'b1;
        accepted   = 1'b0;
        while (!accepted) begin
            @(posedge clk);
            accepted = instrReady;
            @(negedge clk);
            setOutReady();
        end
        instrValid = 1'b0;
        issued++;
        if (predict(ins, inPort, outVal)) begin
            expectQ.push_back(outVal);
        end
    endtask

    // Three unstalled edges in a row empty all stages
    task automatic drain();
        int idle;
        instrValid = 1'b0;
        idle       = 0;
        while (idle < 3) begin
            @(posedge clk);
            idle = outValid ? 0 : idle + 1;
            @(negedge clk);
            setOutReady();
        end
    endtask

    task automatic checkPc();
        assert (pc === modelPc) else begin
            $display("ERROR: pc got %h expected %h", pc, modelPc);
            stopOnError();
        end
    endtask

    // Output port compare in order and exactly once
    always @(posedge clk) begin
        if (rstN && outValid && outReady) begin
            assert (expectQ.size() != 0) else begin
                $display("An output transfer happened with no out instruction pending");
                stopOnError();
            end
            if (expectQ.size() != 0) begin
                assert (outData === expectQ[0]) else begin
                    $display("ERROR: outData got %h expected %h", outData, expectQ[0]);
                    stopOnError();
                end
                void'(expectQ.pop_front());
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        assert (cycles <= 20 * (issued + 1) + resetCycles) else begin
            $display("Timeout, the core made no progress within %0d cycles", cycles);
            stopOnError();
        end
    end

    initial begin
        isaPkg::regIdxT srcA;
        isaPkg::regIdxT srcB;
        isaPkg::regIdxT dest;
        isaPkg::regIdxT prev1;
        isaPkg::regIdxT prev2;
        logic [18:0]    konst;
        clk        = 1'b0;
        rstN       = 1'b0;
        instr      = '0;
        instrValid = 1'b0;
        inPort     = '0;
        outReady   = 1'b1;
        lfsrState  = 32'hfd84d3bb;
        pressure   = 1'b0;
        issued     = 0;
        cycles     = 0;
        clearModel(startPc);
        repeat (resetCycles) @(negedge clk);
        rstN = 1'b1;

        assert (outValid === 1'b0) else begin
            $display("ERROR: outValid got %h expected %h after reset", outValid, 1'b0);
            stopOnError();
        end
        assert (instrReady === 1'b1) else begin
            $display("ERROR: instrReady got %h expected %h after reset", instrReady, 1'b1);
            stopOnError();
        end
        checkPc();

        // ALU and immediate ops on random operands
        for (int round = 0; round < 4; round++) begin
            srcA = randIdx();
            srcB = randIdx();
            issue(buildI(isaPkg::ldi, srcA, 4'd0, randConst()));
            issue(buildI(isaPkg::ldi, srcB, 4'd0, randConst()));
            for (int k = 0; k < 9; k++) begin
                dest = randIdx();
                if (k < 6) begin
                    issue(buildR(isaPkg::opcodeT'(k[4:0]), dest, srcA, srcB));
                end else begin
                    issue(buildI(isaPkg::opcodeT'(k[4:0]), dest, srcA, randConst()));
                end
                issue(buildI(isaPkg::outOp, dest, 4'd0, 19'd0));
            end
        end
        drain();
        checkPc();

        // Dependent chain issuing one instruction every cycle
        prev2 = randIdx();
        prev1 = randIdx();
        issue(buildI(isaPkg::ldi, prev2, 4'd0, randConst()));
        issue(buildI(isaPkg::ldi, prev1, 4'd0, randConst()));
        for (int n = 0; n < 24; n++) begin
            dest = randIdx();
            if (n % 3 == 2) begin
                issue(buildI(isaPkg::addi, dest, prev1, randConst()));
            end else begin
                issue(buildR(isaPkg::opcodeT'(5'(n % 6)), dest, prev1, prev2));
            end
            if (n % 2 == 1) begin
                issue(buildI(isaPkg::outOp, dest, 4'd0, 19'd0));
            end
            prev2 = prev1;
            prev1 = dest;
        end
        drain();
        checkPc();

        // Branches on zero, positive and negative registers
        konst     = randConst();
        konst[18] = 1'b0;
        konst[0]  = 1'b1;
        issue(buildI(isaPkg::ldi, 4'd1, 4'd0, 19'd0));
        issue(buildI(isaPkg::ldi, 4'd2, 4'd0, konst));
        konst     = randConst();
        konst[18] = 1'b1;
        issue(buildI(isaPkg::ldi, 4'd3, 4'd0, konst));
        for (int b = 0; b < 4; b++) begin
            for (int r = 1; r <= 3; r++) begin
                issue(buildI(isaPkg::opcodeT'(5'(isaPkg::brzr + b)), 4'(r), randIdx(),
                             randConst()));
            end
        end
        drain();
        checkPc();

        // Out stream under random back-pressure
        pressure = 1'b1;
        for (int n = 0; n < 30; n++) begin
            dest = randIdx();
            if (n % 3 == 0) begin
                issue(buildI(isaPkg::ldi, dest, 4'd0, randConst()));
            end
            issue(buildI(isaPkg::outOp, dest, 4'd0, 19'd0));
        end
        drain();
        pressure = 1'b0;
        outReady = 1'b1;
        checkPc();

        // Input port held until the in op has passed execute
        for (int n = 0; n < 4; n++) begin
            inPort = takeBits(32);
            dest   = randIdx();
            issue(buildI(isaPkg::inOp, dest, 4'd0, 19'd0));
            issue(buildI(isaPkg::outOp, dest, 4'd0, 19'd0));
            drain();
        end
        checkPc();

        assert (expectQ.size() == 0) else begin
            $display("%0d expected output transfers never happened", expectQ.size());
            stopOnError();
        end
        $display("Testbench passed");
        $finish;
    end

endmodule
